//--- hdl/mul32_pkg.sv
package mul32_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPERAND_W  = 32;
    // one extra bit lets every opcode be handled as a signed multiply.
    localparam int EXT_W      = OPERAND_W + 1;
    localparam int ROW_W      = 2 * EXT_W;
    localparam int NUM_DIGITS = (EXT_W + 1) / 2;
    // the last row carries the negate bits and the sign-extension bits.
    localparam int NUM_ROWS   = NUM_DIGITS + 1;
    localparam int PRODUCT_W  = 2 * OPERAND_W;
    localparam int NUM_STAGES = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // first letter gives the signedness of a, the second that of b.
    typedef enum logic [1:0] {
        OP_UU = 2'b00,
        OP_SU = 2'b10,
        OP_US = 2'b01,
        OP_SS = 2'b11
    } mul_op_e;

    typedef struct packed {
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        mul_op_e              op;
    } mul_req_t;

    typedef logic [NUM_ROWS-1:0][ROW_W-1:0] pp_rows_t;

    typedef struct packed {
        logic [ROW_W-1:0] sum;
        logic [ROW_W-1:0] carry;
    } csa_pair_t;

    typedef logic [PRODUCT_W-1:0] product_t;

endpackage

//--- hdl/booth_stage.sv
`timescale 1ns/1ps

module booth_stage
    import mul32_pkg::*;
(
    input  logic     clk,
    input  mul_req_t in_req,
    input  logic     advance,
    output pp_rows_t rows
);

    mul_req_t                        req_q;
    logic                            a_signed;
    logic                            b_signed;
    logic [EXT_W-1:0]                a_ext;
    logic [EXT_W-1:0]                b_ext;
    logic [EXT_W+1:0]                a_pad;
    logic [NUM_DIGITS-1:0]           neg;
    logic [NUM_DIGITS-1:0]           sel_x1;
    logic [NUM_DIGITS-1:0]           sel_x2;
    logic [NUM_DIGITS-1:0][EXT_W:0]  field;

    always_ff @(posedge clk) begin
        if (advance) begin
            req_q <= in_req;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand extension.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign a_signed = (req_q.op == OP_SU) || (req_q.op == OP_SS);
    assign b_signed = (req_q.op == OP_US) || (req_q.op == OP_SS);

    assign a_ext = {a_signed && req_q.a[OPERAND_W-1], req_q.a};
    assign b_ext = {b_signed && req_q.b[OPERAND_W-1], req_q.b};

    // a zero below bit 0, and the sign repeated above the top, so that every
    // group sees a full triplet.
    assign a_pad = {a_ext[EXT_W-1], a_ext, 1'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // radix-4 digit selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < NUM_DIGITS; g++) begin : g_digit
        logic [2:0]       trip;
        logic [EXT_W-1:0] b_inv;

        assign trip = a_pad[2*g+2 -: 3];

        // the digit 111 is a zero and must not negate.
        assign neg[g]    = trip[2] & ~(trip[1] & trip[0]);
        assign sel_x1[g] = trip[1] ^ trip[0];
        assign sel_x2[g] = (trip[2] & ~trip[1] & ~trip[0]) | (~trip[2] & trip[1] & trip[0]);

        // ones' complement here, the +1 goes into the correction row.
        assign b_inv = {EXT_W{neg[g]}} ^ b_ext;

        assign field[g] = ({(EXT_W + 1){sel_x1[g]}} & {b_inv[EXT_W-1], b_inv})
                        | ({(EXT_W + 1){sel_x2[g]}} & {b_inv, neg[g]});
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row placement and the correction row.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rows = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            rows[i] = ROW_W'(field[i]) << (2 * i);

            // sign-extension constants sum to minus the weights of the
            // inverted sign bits placed in the correction row.
            if (i == 0) begin
                rows[i][EXT_W+2 -: 2] = 2'b11;
            end else if (i < NUM_DIGITS - 1) begin
                rows[i][2*i+EXT_W+2] = 1'b1;
            end

            rows[NUM_ROWS-1][2*i] = neg[i];

            // the top row's sign falls outside the product width.
            if (i < NUM_DIGITS - 1) begin
                rows[NUM_ROWS-1][2*i+EXT_W+1] = ~field[i][EXT_W];
            end
        end
    end

endmodule

//--- hdl/csa_stage.sv
`timescale 1ns/1ps

module csa_stage
    import mul32_pkg::*;
(
    input  logic      clk,
    input  logic      advance,
    input  pp_rows_t  rows,
    output csa_pair_t pair
);

    csa_pair_t l1 [6];
    csa_pair_t l2 [4];
    csa_pair_t l3 [2];
    csa_pair_t l4 [2];
    csa_pair_t l5;
    csa_pair_t l6;

    // one layer of full adders, the carry vector moved up one place.
    function automatic csa_pair_t csa3(input logic [ROW_W-1:0] x,
                                       input logic [ROW_W-1:0] y,
                                       input logic [ROW_W-1:0] z);
        csa_pair_t  res;
        logic [ROW_W-1:0] maj;

        maj       = (x & y) | (x & z) | (y & z);
        res.sum   = x ^ y ^ z;
        res.carry = {maj[ROW_W-2:0], 1'b0};
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reduction 18 -> 12 -> 8 -> 6 -> 4 -> 3 -> 2.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            l1[i] = csa3(rows[3*i], rows[3*i+1], rows[3*i+2]);
        end

        l2[0] = csa3(l1[0].sum, l1[1].sum, l1[2].sum);
        l2[1] = csa3(l1[3].sum, l1[4].sum, l1[5].sum);
        l2[2] = csa3(l1[0].carry, l1[1].carry, l1[2].carry);
        l2[3] = csa3(l1[3].carry, l1[4].carry, l1[5].carry);

        l3[0] = csa3(l2[0].sum, l2[1].sum, l2[2].sum);
        l3[1] = csa3(l2[3].sum, l2[0].carry, l2[1].carry);

        // two carries from layer two only join here
        l4[0] = csa3(l2[2].carry, l2[3].carry, l3[0].sum);
        l4[1] = csa3(l3[1].sum, l3[0].carry, l3[1].carry);

        l5 = csa3(l4[0].sum, l4[1].sum, l4[0].carry);
        l6 = csa3(l4[1].carry, l5.sum, l5.carry);
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pair <= l6;
        end
    end

endmodule

//--- hdl/product_stage.sv
`timescale 1ns/1ps

module product_stage
    import mul32_pkg::*;
(
    input  logic      clk,
    input  logic      advance,
    input  csa_pair_t pair,
    output product_t  product
);

    product_t total;

    // the upper bits of the pair only hold sign-extension residue, so the
    // adder stops at the product width.
    assign total = pair.sum[PRODUCT_W-1:0] + pair.carry[PRODUCT_W-1:0];

    always_ff @(posedge clk) begin
        if (advance) begin
            product <= total;
        end
    end

endmodule

//--- hdl/mul_stage_ctrl.sv
`timescale 1ns/1ps

module mul_stage_ctrl
    import mul32_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic out_ready,
    output logic in_ready,
    output logic advance,
    output logic out_valid
);

    // bit 0 is the request register, the top bit the product register.
    logic [NUM_STAGES-1:0] stage_valid;

    // the whole pipe moves together, so an empty output slot or a taken
    // product is enough to let every stage step.
    assign advance   = !stage_valid[NUM_STAGES-1] || out_ready;
    assign in_ready  = advance;
    assign out_valid = stage_valid[NUM_STAGES-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[NUM_STAGES-2:0], in_valid};
        end
    end

endmodule

//--- hdl/mul32.sv
`timescale 1ns/1ps

module mul32
    import mul32_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  mul_req_t in_req,
    output logic     in_ready,
    output logic     out_valid,
    output product_t out_product,
    input  logic     out_ready
);

    logic      advance;
    pp_rows_t  rows;
    csa_pair_t pair;

    mul_stage_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .advance   (advance),
        .out_valid (out_valid)
    );

    booth_stage i_booth (
        .clk     (clk),
        .in_req  (in_req),
        .advance (advance),
        .rows    (rows)
    );

    csa_stage i_csa (
        .clk     (clk),
        .advance (advance),
        .rows    (rows),
        .pair    (pair)
    );

    product_stage i_product (
        .clk     (clk),
        .advance (advance),
        .pair    (pair),
        .product (out_product)
    );

endmodule

//--- bench/mul32_asserts.sv
`timescale 1ns/1ps

module mul32_asserts
    import mul32_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     in_ready,
    input logic     out_valid,
    input logic     out_ready,
    input product_t out_product
);

    // reset empties every stage, so nothing is offered right after it.
    a_idle_after_reset : assert property (
        @(posedge clk) !rst_n |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

    // a product that is not taken must stay on the port unchanged.
    a_hold_under_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_product))
    ) else $error("out_product or out_valid changed while stalled");

    a_ready_follows_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        in_ready == !(out_valid && !out_ready)
    ) else $error("in_ready does not match the stall condition");

endmodule

bind mul32 mul32_asserts i_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_product (out_product)
);

//--- bench/tb_mul32.sv
`timescale 1ns/1ps

module tb_mul32
    import mul32_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_ENTRIES = 16;
    localparam int NUM_STREAM  = 200;
    localparam int NUM_BURST   = 20;
    localparam int DRAIN_LIMIT = 100;
    localparam int TIMEOUT_NS  = (NUM_ENTRIES + 2 * NUM_STREAM + NUM_BURST) * 20 * CLK_PERIOD;

    typedef struct packed {
        mul_req_t req;
        product_t expected;
    } vector_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    mul_req_t in_req;
    logic     in_ready;
    logic     out_valid;
    product_t out_product;
    logic     out_ready;

    int       seed = 45796;
    product_t exp_in;
    product_t exp_q [$];
    vector_t  vectors [$];
    logic     ready_pattern [1024];
    logic     ready_random = 1'b0;
    logic     burst_mode = 1'b0;
    int       ready_idx = 0;
    int       in_count = 0;
    int       out_count = 0;
    int       edge_cnt = 0;
    int       burst_in_edge = -1;
    int       burst_out_edge = -1;

    mul32 i_mul32 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_product (out_product),
        .out_ready   (out_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_product(input product_t actual, input product_t expected);
        if (actual !== expected) begin
            $display("FAILED out_product: expected %h, got %h", expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // each operand is widened by its own letter of the opcode.
    function automatic product_t model_product(input mul_req_t req);
        logic                 a_sign;
        logic                 b_sign;
        logic [PRODUCT_W-1:0] a_wide;
        logic [PRODUCT_W-1:0] b_wide;

        a_sign = (req.op == OP_SU || req.op == OP_SS) && req.a[OPERAND_W-1];
        b_sign = (req.op == OP_US || req.op == OP_SS) && req.b[OPERAND_W-1];
        a_wide = {{OPERAND_W{a_sign}}, req.a};
        b_wide = {{OPERAND_W{b_sign}}, req.b};
        return a_wide * b_wide;
    endfunction

    function automatic mul_req_t random_req();
        mul_req_t    req;
        logic [31:0] pick;

        req.a  = $random(seed);
        req.b  = $random(seed);
        pick   = $random(seed);
        req.op = mul_op_e'(pick[1:0]);
        return req;
    endfunction

    function automatic void add_vector(input logic [31:0] a, input logic [31:0] b,
                                       input mul_op_e op, input product_t expected);
        vector_t v;

        v.req.a    = a;
        v.req.b    = b;
        v.req.op   = op;
        v.expected = expected;
        vectors.push_back(v);
    endfunction

    // corner operands that hit the negate and x2 digits and the top group.
    function automatic void load_vectors();
        add_vector(32'h00000000, 32'h00000000, OP_UU, 64'h0000000000000000);
        add_vector(32'h00000001, 32'h00000001, OP_SS, 64'h0000000000000001);
        add_vector(32'hFFFFFFFF, 32'hFFFFFFFF, OP_UU, 64'hFFFFFFFE00000001);
        add_vector(32'hFFFFFFFF, 32'hFFFFFFFF, OP_SS, 64'h0000000000000001);
        add_vector(32'hFFFFFFFF, 32'h00000001, OP_SU, 64'hFFFFFFFFFFFFFFFF);
        add_vector(32'h00000001, 32'hFFFFFFFF, OP_US, 64'hFFFFFFFFFFFFFFFF);
        add_vector(32'hFFFFFFFF, 32'h00000001, OP_US, 64'h00000000FFFFFFFF);
        add_vector(32'h80000000, 32'h80000000, OP_SS, 64'h4000000000000000);
        add_vector(32'h80000000, 32'h80000000, OP_UU, 64'h4000000000000000);
        add_vector(32'h80000000, 32'h7FFFFFFF, OP_SU, 64'hC000000080000000);
        add_vector(32'h7FFFFFFF, 32'h7FFFFFFF, OP_SS, 64'h3FFFFFFF00000001);
        add_vector(32'h7FFFFFFF, 32'h80000000, OP_US, 64'hC000000080000000);
        add_vector(32'hAAAAAAAA, 32'h00000002, OP_UU, 64'h0000000155555554);
        add_vector(32'hAAAAAAAA, 32'h00000002, OP_SS, 64'hFFFFFFFF55555554);
        add_vector(32'h55555555, 32'hFFFFFFFF, OP_US, 64'hFFFFFFFFAAAAAAAB);
        add_vector(32'h55555555, 32'h00000003, OP_SU, 64'h00000000FFFFFFFF);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_req(input mul_req_t req, input product_t expected);
        in_valid = 1'b1;
        in_req   = req;
        exp_in   = expected;
        do begin
            @(posedge clk);
        end while (!in_ready);
        #1;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int waited;

        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (ready_random) begin
                out_ready = ready_pattern[ready_idx];
                ready_idx = (ready_idx + 1) % 1024;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // transfers are taken from the values that were stable up to the edge.
    always @(posedge clk) begin
        if (rst_n) begin
            edge_cnt++;
            if (burst_mode && in_valid) begin
                check_flag("in_ready", in_ready, 1'b1);
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(exp_in);
                in_count++;
                if (burst_mode && burst_in_edge < 0) begin
                    burst_in_edge = edge_cnt;
                end
            end
            if (out_valid && out_ready) begin
                out_count++;
                if (burst_mode && burst_out_edge < 0) begin
                    burst_out_edge = edge_cnt;
                end
                if (exp_q.size() == 0) begin
                    $display("a product came out with no request outstanding");
                    stop_on_error();
                end else begin
                    check_product(out_product, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("the run timed out after %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        mul_req_t req;
        int       base_in;
        int       base_out;

        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        exp_in   = '0;
        load_vectors();
        for (int i = 0; i < 1024; i++) begin
            ready_pattern[i] = 1'($random(seed));
        end

        repeat (3) @(posedge clk);
        #1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        foreach (vectors[i]) begin
            send_req(vectors[i].req, vectors[i].expected);
        end
        idle_cycle();
        drain();

        for (int i = 0; i < NUM_STREAM; i++) begin
            req = random_req();
            send_req(req, model_product(req));
        end
        idle_cycle();
        drain();
        check_count("transfer count", out_count, in_count);

        ready_random = 1'b1;
        for (int i = 0; i < NUM_STREAM; i++) begin
            if (($random(seed) & 3) == 0) begin
                idle_cycle();
            end
            req = random_req();
            send_req(req, model_product(req));
        end
        idle_cycle();
        drain();
        ready_random = 1'b0;
        idle_cycle();
        check_count("transfer count", out_count, in_count);

        base_in    = in_count;
        base_out   = out_count;
        burst_mode = 1'b1;
        for (int i = 0; i < NUM_BURST; i++) begin
            req = random_req();
            send_req(req, model_product(req));
        end
        idle_cycle();
        drain();
        burst_mode = 1'b0;
        check_count("burst inputs", in_count - base_in, NUM_BURST);
        check_count("burst outputs", out_count - base_out, NUM_BURST);
        // out_valid rises after edge k+2, so the first product is taken at edge k+3.
        check_count("burst latency", burst_out_edge - burst_in_edge, 3);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- mul32.f
hdl/mul32_pkg.sv
hdl/booth_stage.sv
hdl/csa_stage.sv
hdl/product_stage.sv
hdl/mul_stage_ctrl.sv
hdl/mul32.sv
bench/mul32_asserts.sv
bench/tb_mul32.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mul32
FILELIST  ?= mul32.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# The run passes only when the pass message shows up in the simulator output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
